/* source/rv_mini_core_settings.svh */
`ifndef RV_MINI_CORE_SETTINGS_SVH
`define RV_MINI_CORE_SETTINGS_SVH

// Datapath and address width
`define RV_XLEN 32

// Register file geometry
`define RV_RF_ADDR_W 5
`define RV_NUM_REGS 32

// Byte distance between sequential fetches
`define RV_INSTR_STEP 4

// Major opcodes, bits [6:0] of the instruction
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_OP 7'b0110011
`define RV_OPC_LUI 7'b0110111
`define RV_OPC_STORE 7'b0100011

`endif

/* source/rv_mini_core_pkg.sv */
`include "rv_mini_core_settings.svh"

package rv_mini_core_pkg;

  // Data, address and instruction word
  typedef logic [`RV_XLEN-1:0] word_t;

  // Register index
  typedef logic [`RV_RF_ADDR_W-1:0] rf_addr_t;

  // ALU functions used by the supported subset
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  // Instruction fetch FSM
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT
  } fetch_state_e;

  // Fetched word handed to decode
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } if_id_pipe_t;

  // Decoded operation handed to execute
  typedef struct packed {
    logic     valid;
    alu_op_e  alu_op;
    word_t    operand_a;
    word_t    operand_b;
    logic     rf_we;
    rf_addr_t rf_waddr;
    logic     store_en;
    word_t    store_data;
  } id_ex_pipe_t;

  // Register write, also the forward path into decode
  typedef struct packed {
    logic     we;
    rf_addr_t waddr;
    word_t    wdata;
  } rf_wr_t;

endpackage

/* source/rv_register_file.sv */
`timescale 1ns/1ps
`include "rv_mini_core_settings.svh"

module rv_register_file (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  rv_mini_core_pkg::rf_addr_t raddr_a_i,
  input  rv_mini_core_pkg::rf_addr_t raddr_b_i,
  output rv_mini_core_pkg::word_t    rdata_a_o,
  output rv_mini_core_pkg::word_t    rdata_b_o,
  input  rv_mini_core_pkg::rf_wr_t   wr_i
);

  // x1 to x31, no storage for x0
  rv_mini_core_pkg::word_t regs_q [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.we && wr_i.waddr != '0) begin
      regs_q[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // Old value on same-cycle write, ID forwards that case
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* source/rv_if_stage.sv */
`timescale 1ns/1ps
`include "rv_mini_core_settings.svh"

module rv_if_stage (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          fetch_enable_i,
  input  rv_mini_core_pkg::word_t       boot_addr_i,
  output logic                          instr_req_o,
  output rv_mini_core_pkg::word_t       instr_addr_o,
  input  logic                          instr_gnt_i,
  input  logic                          instr_rvalid_i,
  input  rv_mini_core_pkg::word_t       instr_rdata_i,
  input  logic                          id_ready_i,
  output rv_mini_core_pkg::if_id_pipe_t if_id_pipe_o
);

  rv_mini_core_pkg::fetch_state_e state_q;
  rv_mini_core_pkg::fetch_state_e state_d;
  rv_mini_core_pkg::word_t        pc_q;
  rv_mini_core_pkg::word_t        fetch_pc;
  rv_mini_core_pkg::word_t        hold_instr_q;
  rv_mini_core_pkg::word_t        if_id_pc_q;
  rv_mini_core_pkg::word_t        if_id_instr_q;
  logic                           hold_valid_q;
  logic                           if_id_valid_q;
  logic                           if_id_free;
  logic                           load_rdata;
  logic                           load_hold;
  logic                           load_if_id;

  // Slot free when empty or being taken by ID this cycle
  assign if_id_free = !if_id_valid_q || id_ready_i;
  assign load_rdata = (state_q == rv_mini_core_pkg::FETCH_WAIT) && instr_rvalid_i && if_id_free;
  assign load_hold  = hold_valid_q && if_id_free;
  assign load_if_id = load_rdata || load_hold;

  // pc_q already stepped at gnt
  assign fetch_pc = pc_q - rv_mini_core_pkg::word_t'(`RV_INSTR_STEP);

  ////////////////////
  // Fetch FSM
  ////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      rv_mini_core_pkg::FETCH_IDLE: if (fetch_enable_i) state_d = rv_mini_core_pkg::FETCH_REQ;
      rv_mini_core_pkg::FETCH_REQ:  if (instr_gnt_i) state_d = rv_mini_core_pkg::FETCH_WAIT;
      // Next request only once the word has somewhere to go
      rv_mini_core_pkg::FETCH_WAIT: if (load_if_id) state_d = rv_mini_core_pkg::FETCH_REQ;
      default:                      state_d = rv_mini_core_pkg::FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q       <= rv_mini_core_pkg::FETCH_IDLE;
      pc_q          <= '0;
      hold_valid_q  <= 1'b0;
      if_id_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Boot address taken at start
      if (state_q == rv_mini_core_pkg::FETCH_IDLE && fetch_enable_i) begin
        pc_q <= boot_addr_i;
      end else if (instr_req_o && instr_gnt_i) begin
        pc_q <= pc_q + rv_mini_core_pkg::word_t'(`RV_INSTR_STEP);
      end
      // Parked response while ID is blocked
      if (state_q == rv_mini_core_pkg::FETCH_WAIT && instr_rvalid_i && !if_id_free) begin
        hold_valid_q <= 1'b1;
      end else if (load_hold) begin
        hold_valid_q <= 1'b0;
      end
      if (load_if_id) begin
        if_id_valid_q <= 1'b1;
      end else if (id_ready_i) begin
        if_id_valid_q <= 1'b0;
      end
    end
  end

  // Payload, qualified by the valid bits
  always_ff @(posedge clk_i) begin
    if (state_q == rv_mini_core_pkg::FETCH_WAIT && instr_rvalid_i) begin
      hold_instr_q <= instr_rdata_i;
    end
    if (load_if_id) begin
      if_id_pc_q    <= fetch_pc;
      if_id_instr_q <= hold_valid_q ? hold_instr_q : instr_rdata_i;
    end
  end

  assign instr_req_o  = (state_q == rv_mini_core_pkg::FETCH_REQ);
  assign instr_addr_o = pc_q;
  assign if_id_pipe_o = '{valid: if_id_valid_q, pc: if_id_pc_q, instr: if_id_instr_q};

  // OBI: pending request keeps req and address
  a_instr_addr_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o)
  );

endmodule

/* source/rv_id_stage.sv */
`timescale 1ns/1ps
`include "rv_mini_core_settings.svh"

module rv_id_stage (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  rv_mini_core_pkg::if_id_pipe_t if_id_pipe_i,
  output logic                          id_ready_o,
  input  logic                          ex_stall_i,
  output rv_mini_core_pkg::rf_addr_t    rf_raddr_a_o,
  output rv_mini_core_pkg::rf_addr_t    rf_raddr_b_o,
  input  rv_mini_core_pkg::word_t       rf_rdata_a_i,
  input  rv_mini_core_pkg::word_t       rf_rdata_b_i,
  input  rv_mini_core_pkg::rf_wr_t      ex_fwd_i,
  output rv_mini_core_pkg::id_ex_pipe_t id_ex_pipe_o
);

  rv_mini_core_pkg::word_t       instr;
  rv_mini_core_pkg::word_t       imm_i;
  rv_mini_core_pkg::word_t       imm_s;
  rv_mini_core_pkg::word_t       imm_u;
  rv_mini_core_pkg::word_t       imm;
  rv_mini_core_pkg::word_t       rs1_val;
  rv_mini_core_pkg::word_t       rs2_val;
  rv_mini_core_pkg::word_t       pc_last_q;
  rv_mini_core_pkg::rf_addr_t    rs1;
  rv_mini_core_pkg::rf_addr_t    rs2;
  rv_mini_core_pkg::rf_addr_t    rd;
  rv_mini_core_pkg::alu_op_e     alu_op;
  rv_mini_core_pkg::id_ex_pipe_t id_ex_d;
  rv_mini_core_pkg::id_ex_pipe_t ex_payload_q;
  logic [6:0]                    opcode;
  logic [6:0]                    funct7;
  logic [2:0]                    funct3;
  logic                          use_imm;
  logic                          insn_ok;
  logic                          is_store;
  logic                          ex_valid_q;
  logic                          pc_seen_q;
  logic                          accept;

  // Field split
  assign instr  = if_id_pipe_i.instr;
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  // Sign extended I and S, U left aligned
  assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  ////////////////////
  // Decoder
  ////////////////////
  always_comb begin
    alu_op   = rv_mini_core_pkg::ALU_ADD;
    imm      = imm_i;
    use_imm  = 1'b0;
    insn_ok  = 1'b0;
    is_store = 1'b0;
    case (opcode)
      `RV_OPC_OP_IMM: begin
        use_imm = 1'b1;
        insn_ok = 1'b1;
        case (funct3)
          3'b000:  alu_op = rv_mini_core_pkg::ALU_ADD;
          3'b100:  alu_op = rv_mini_core_pkg::ALU_XOR;
          3'b110:  alu_op = rv_mini_core_pkg::ALU_OR;
          3'b111:  alu_op = rv_mini_core_pkg::ALU_AND;
          default: insn_ok = 1'b0;
        endcase
      end
      `RV_OPC_OP: begin
        // SUB is the only funct7 variant kept
        insn_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000 && funct3 == 3'b000);
        case (funct3)
          3'b000:  alu_op = funct7[5] ? rv_mini_core_pkg::ALU_SUB : rv_mini_core_pkg::ALU_ADD;
          3'b100:  alu_op = rv_mini_core_pkg::ALU_XOR;
          3'b110:  alu_op = rv_mini_core_pkg::ALU_OR;
          3'b111:  alu_op = rv_mini_core_pkg::ALU_AND;
          default: insn_ok = 1'b0;
        endcase
      end
      `RV_OPC_LUI: begin
        alu_op  = rv_mini_core_pkg::ALU_PASS_B;
        imm     = imm_u;
        use_imm = 1'b1;
        insn_ok = 1'b1;
      end
      `RV_OPC_STORE: begin
        // SW only, address is rs1 + S-immediate
        imm      = imm_s;
        use_imm  = 1'b1;
        is_store = 1'b1;
        insn_ok  = (funct3 == 3'b010);
      end
      default: insn_ok = 1'b0;
    endcase
  end

  ////////////////////
  // Operands
  ////////////////////
  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;

  // EX result bypasses the register file write
  assign rs1_val = (ex_fwd_i.we && ex_fwd_i.waddr != '0 && ex_fwd_i.waddr == rs1) ?
                   ex_fwd_i.wdata : rf_rdata_a_i;
  assign rs2_val = (ex_fwd_i.we && ex_fwd_i.waddr != '0 && ex_fwd_i.waddr == rs2) ?
                   ex_fwd_i.wdata : rf_rdata_b_i;

  always_comb begin
    id_ex_d            = ex_payload_q;
    id_ex_d.valid      = if_id_pipe_i.valid;
    id_ex_d.alu_op     = alu_op;
    id_ex_d.operand_a  = rs1_val;
    id_ex_d.operand_b  = use_imm ? imm : rs2_val;
    // Writes to x0 dropped here
    id_ex_d.rf_we      = insn_ok && !is_store && (rd != '0);
    id_ex_d.rf_waddr   = rd;
    id_ex_d.store_en   = insn_ok && is_store;
    id_ex_d.store_data = rs2_val;
  end

  // ID/EX frozen while a store waits
  assign id_ready_o = !ex_stall_i;
  assign accept     = if_id_pipe_i.valid && id_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_valid_q <= 1'b0;
      pc_seen_q  <= 1'b0;
    end else begin
      if (!ex_stall_i) ex_valid_q <= if_id_pipe_i.valid;
      if (accept) pc_seen_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!ex_stall_i) ex_payload_q <= id_ex_d;
    if (accept) pc_last_q <= if_id_pipe_i.pc;
  end

  always_comb begin
    id_ex_pipe_o       = ex_payload_q;
    id_ex_pipe_o.valid = ex_valid_q;
  end

  // Straight-line fetch, so decode sees consecutive PCs
  a_pc_in_order: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    accept && pc_seen_q |->
      if_id_pipe_i.pc == pc_last_q + rv_mini_core_pkg::word_t'(`RV_INSTR_STEP)
  );

endmodule

/* source/rv_ex_stage.sv */
`timescale 1ns/1ps

module rv_ex_stage (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  rv_mini_core_pkg::id_ex_pipe_t id_ex_pipe_i,
  output logic                          ex_stall_o,
  output rv_mini_core_pkg::rf_wr_t      rf_wr_o,
  output logic                          data_req_o,
  output rv_mini_core_pkg::word_t       data_addr_o,
  output rv_mini_core_pkg::word_t       data_wdata_o,
  input  logic                          data_gnt_i
);

  rv_mini_core_pkg::word_t alu_result;
  rv_mini_core_pkg::word_t op_a;
  rv_mini_core_pkg::word_t op_b;

  assign op_a = id_ex_pipe_i.operand_a;
  assign op_b = id_ex_pipe_i.operand_b;

  ////////////////////
  // ALU
  ////////////////////
  always_comb begin
    case (id_ex_pipe_i.alu_op)
      rv_mini_core_pkg::ALU_SUB:    alu_result = op_a - op_b;
      rv_mini_core_pkg::ALU_AND:    alu_result = op_a & op_b;
      rv_mini_core_pkg::ALU_OR:     alu_result = op_a | op_b;
      rv_mini_core_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      // LUI immediate goes through unchanged
      rv_mini_core_pkg::ALU_PASS_B: alu_result = op_b;
      default:                      alu_result = op_a + op_b;
    endcase
  end

  // Writeback at the end of this cycle, also seen by ID
  assign rf_wr_o = '{
    we:    id_ex_pipe_i.valid && id_ex_pipe_i.rf_we,
    waddr: id_ex_pipe_i.rf_waddr,
    wdata: alu_result
  };

  ////////////////////
  // Store port
  ////////////////////
  // ALU result is the effective address for SW
  assign data_req_o   = id_ex_pipe_i.valid && id_ex_pipe_i.store_en;
  assign data_addr_o  = alu_result;
  assign data_wdata_o = id_ex_pipe_i.store_data;

  // Done in the gnt cycle, no response phase
  assign ex_stall_o = data_req_o && !data_gnt_i;

  // Held store relies on the frozen ID/EX register
  a_store_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    data_req_o && !data_gnt_i |=>
      data_req_o && $stable(data_addr_o) && $stable(data_wdata_o)
  );

  // Decode never flags x0 as a destination
  a_no_x0_write: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rf_wr_o.we |-> rf_wr_o.waddr != '0
  );

endmodule

/* source/rv_mini_core.sv */
`timescale 1ns/1ps

module rv_mini_core (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    fetch_enable_i,
  input  rv_mini_core_pkg::word_t boot_addr_i,

  // Instruction port
  output logic                    instr_req_o,
  output rv_mini_core_pkg::word_t instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  rv_mini_core_pkg::word_t instr_rdata_i,

  // Data port, stores only
  output logic                    data_req_o,
  output rv_mini_core_pkg::word_t data_addr_o,
  output rv_mini_core_pkg::word_t data_wdata_o,
  input  logic                    data_gnt_i
);

  // Stage to stage
  rv_mini_core_pkg::if_id_pipe_t if_id_pipe;
  rv_mini_core_pkg::id_ex_pipe_t id_ex_pipe;
  rv_mini_core_pkg::rf_wr_t      rf_wr_ex;
  logic                          id_ready;
  logic                          ex_stall;

  // Register file read side
  rv_mini_core_pkg::rf_addr_t    rf_raddr_a;
  rv_mini_core_pkg::rf_addr_t    rf_raddr_b;
  rv_mini_core_pkg::word_t       rf_rdata_a;
  rv_mini_core_pkg::word_t       rf_rdata_b;

  ////////////////////
  // Fetch
  ////////////////////
  rv_if_stage if_stage_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .id_ready_i     ( id_ready       ),
    .if_id_pipe_o   ( if_id_pipe     )
  );

  ////////////////////
  // Decode
  ////////////////////
  rv_id_stage id_stage_i (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .if_id_pipe_i ( if_id_pipe ),
    .id_ready_o   ( id_ready   ),
    .ex_stall_i   ( ex_stall   ),
    .rf_raddr_a_o ( rf_raddr_a ),
    .rf_raddr_b_o ( rf_raddr_b ),
    .rf_rdata_a_i ( rf_rdata_a ),
    .rf_rdata_b_i ( rf_rdata_b ),
    .ex_fwd_i     ( rf_wr_ex   ),
    .id_ex_pipe_o ( id_ex_pipe )
  );

  ////////////////////
  // Execute
  ////////////////////
  rv_ex_stage ex_stage_i (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .id_ex_pipe_i ( id_ex_pipe   ),
    .ex_stall_o   ( ex_stall     ),
    .rf_wr_o      ( rf_wr_ex     ),
    .data_req_o   ( data_req_o   ),
    .data_addr_o  ( data_addr_o  ),
    .data_wdata_o ( data_wdata_o ),
    .data_gnt_i   ( data_gnt_i   )
  );

  // Written by EX, read by ID
  rv_register_file register_file_i (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .raddr_a_i ( rf_raddr_a ),
    .raddr_b_i ( rf_raddr_b ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b ),
    .wr_i      ( rf_wr_ex   )
  );

endmodule

/* testbench/tb_rv_mini_core.sv */
`timescale 1ns/1ps
`include "rv_mini_core_settings.svh"

module tb_rv_mini_core;

  localparam rv_mini_core_pkg::word_t BOOT_ADDR = 32'h0000_0080;
  // ADDI x0, x0, 0 for addresses outside the program
  localparam rv_mini_core_pkg::word_t NOP_WORD = {25'b0, `RV_OPC_OP_IMM};

  typedef struct packed {
    rv_mini_core_pkg::word_t addr;
    rv_mini_core_pkg::word_t data;
  } store_rec_t;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    fetch_enable_i;
  rv_mini_core_pkg::word_t boot_addr_i;
  logic                    instr_req_o;
  rv_mini_core_pkg::word_t instr_addr_o;
  logic                    instr_gnt_i = 1'b0;
  logic                    instr_rvalid_i = 1'b0;
  rv_mini_core_pkg::word_t instr_rdata_i = '0;
  logic                    data_req_o;
  rv_mini_core_pkg::word_t data_addr_o;
  rv_mini_core_pkg::word_t data_wdata_o;
  logic                    data_gnt_i = 1'b0;

  // Program image and expected stores, in program order
  rv_mini_core_pkg::word_t imem [rv_mini_core_pkg::word_t];
  store_rec_t              exp_q [$];
  string                   name_q [$];
  int unsigned             n_lines = 0;
  int unsigned             cycle_cnt = 0;
  int unsigned             cycle_limit;
  int unsigned             tests_passed = 0;
  int unsigned             tests_failed = 0;
  int unsigned             other_errors = 0;
  // Fetch side model state
  rv_mini_core_pkg::word_t exp_fetch_addr = BOOT_ADDR;
  rv_mini_core_pkg::word_t rsp_addr;
  int unsigned             fetch_cnt = 0;
  int unsigned             fetch_errs = 0;
  int unsigned             igrant_wait = 0;
  int unsigned             rsp_wait = 0;
  bit                      rsp_busy = 1'b0;
  bit                      idle_err = 1'b0;
  // Store side model state
  int unsigned             dgrant_wait = 0;
  bit                      hold_seen = 1'b0;
  bit                      hold_err = 1'b0;
  rv_mini_core_pkg::word_t hold_addr;
  rv_mini_core_pkg::word_t hold_data;

  rv_mini_core dut_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .data_req_o     ( data_req_o     ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   ),
    .data_gnt_i     ( data_gnt_i     )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////
  function automatic rv_mini_core_pkg::word_t fetch_word(rv_mini_core_pkg::word_t addr);
    if (imem.exists(addr)) return imem[addr];
    return NOP_WORD;
  endfunction

  task automatic record_result(string tname, bit ok);
    if (ok) begin
      tests_passed++;
      $display("PASS %s", tname);
    end else begin
      tests_failed++;
      $display("FAIL %s", tname);
    end
  endtask

  // P lines fill the program, S lines queue expected stores
  task automatic load_input_file();
    int                      fd;
    int                      n;
    string                   line;
    string                   kind;
    string                   tname;
    rv_mini_core_pkg::word_t a;
    rv_mini_core_pkg::word_t d;
    store_rec_t              rec;
    fd = $fopen("testbench/rv_mini_core_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/rv_mini_core_input.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line[0] != "#" && $sscanf(line, "%s", kind) == 1) begin
        n_lines++;
        if (kind == "P" && $sscanf(line, "%s %h %h", kind, a, d) == 3) begin
          imem[a] = d;
        end else if (kind == "S" && $sscanf(line, "%s %s %h %h", kind, tname, a, d) == 4) begin
          rec.addr = a;
          rec.data = d;
          exp_q.push_back(rec);
          name_q.push_back(tname);
        end else begin
          $display("malformed line in input file: %s", line);
          other_errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  ////////////////////
  // Instruction memory
  ////////////////////
  task automatic fetch_model();
    // Address phase, gnt low for 0 to 3 cycles of each pending request
    if (instr_req_o && instr_gnt_i) begin
      fetch_cnt++;
      if (instr_addr_o != exp_fetch_addr) begin
        $display("CHECK FAILED fetch_order: expected %08h, actual %08h",
                 exp_fetch_addr, instr_addr_o);
        fetch_errs++;
      end
      exp_fetch_addr = exp_fetch_addr + `RV_INSTR_STEP;
      rsp_addr    = instr_addr_o;
      rsp_busy    = 1'b1;
      rsp_wait    = $urandom % 3;
      igrant_wait = $urandom % 4;
    end else if (instr_req_o && igrant_wait != 0) begin
      igrant_wait--;
    end
    instr_gnt_i <= (igrant_wait == 0);
    // Response 1 to 3 cycles after the accept
    instr_rvalid_i <= 1'b0;
    if (rsp_busy) begin
      if (rsp_wait == 0) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= fetch_word(rsp_addr);
        rsp_busy = 1'b0;
      end else begin
        rsp_wait--;
      end
    end
  endtask

  ////////////////////
  // Data memory
  ////////////////////
  task automatic store_model();
    store_rec_t exp_rec;
    string      tname;
    bit         ok;
    // Stalled request keeps address and data
    if (hold_seen) begin
      if (!data_req_o || data_addr_o != hold_addr || data_wdata_o != hold_data) begin
        tname = (name_q.size() != 0) ? name_q[0] : "unexpected";
        $display("CHECK FAILED %s: held store expected %08h/%08h, actual req %b %08h/%08h",
                 tname, hold_addr, hold_data, data_req_o, data_addr_o, data_wdata_o);
        hold_err = 1'b1;
      end
    end
    hold_seen = data_req_o && !data_gnt_i;
    hold_addr = data_addr_o;
    hold_data = data_wdata_o;
    if (data_req_o && data_gnt_i) begin
      if (exp_q.size() == 0) begin
        $display("store to %08h with data %08h arrived after the last expected store",
                 data_addr_o, data_wdata_o);
        other_errors++;
      end else begin
        exp_rec = exp_q.pop_front();
        tname   = name_q.pop_front();
        ok      = !hold_err;
        if (data_addr_o != exp_rec.addr) begin
          $display("CHECK FAILED %s: address expected %08h, actual %08h",
                   tname, exp_rec.addr, data_addr_o);
          ok = 1'b0;
        end
        if (data_wdata_o != exp_rec.data) begin
          $display("CHECK FAILED %s: data expected %08h, actual %08h",
                   tname, exp_rec.data, data_wdata_o);
          ok = 1'b0;
        end
        hold_err = 1'b0;
        record_result(tname, ok);
      end
      dgrant_wait = $urandom % 4;
    end else if (data_req_o && dgrant_wait != 0) begin
      dgrant_wait--;
    end
    data_gnt_i <= (dgrant_wait == 0);
  endtask

  initial begin
    // Fixed seed for the gnt and rvalid delays
    void'($urandom(79645));
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      if (rst_n_i) begin
        if (!fetch_enable_i && (instr_req_o || data_req_o)) begin
          $display("request raised while fetch was still disabled");
          idle_err = 1'b1;
        end
        fetch_model();
        store_model();
      end
    end
  end

  ////////////////////
  // Sequence
  ////////////////////
  initial begin
    rst_n_i        <= 1'b0;
    fetch_enable_i <= 1'b0;
    boot_addr_i    <= BOOT_ADDR;
    load_input_file();
    cycle_limit = 64 * n_lines + 200;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Idle window with fetch disabled
    repeat (10) @(posedge clk_i);
    fetch_enable_i <= 1'b1;
    @(posedge clk_i);
    record_result("idle_no_req", !idle_err);
    while (exp_q.size() != 0 && cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
    end
    if (exp_q.size() != 0) begin
      $display("timeout after %0d cycles, %0d expected stores went missing",
               cycle_cnt, exp_q.size());
      other_errors++;
    end else begin
      // Drain so that extra stores show up
      repeat (30) @(posedge clk_i);
    end
    record_result("fetch_order", fetch_errs == 0 && fetch_cnt != 0);
    $display("tests: %0d passed, %0d failed, %0d other errors",
             tests_passed, tests_failed, other_errors);
    if (tests_failed == 0 && other_errors == 0 && !hold_err) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* rv_mini_core.f */
+incdir+source
source/rv_mini_core_pkg.sv
source/rv_register_file.sv
source/rv_if_stage.sv
source/rv_id_stage.sv
source/rv_ex_stage.sv
source/rv_mini_core.sv
testbench/tb_rv_mini_core.sv

/* Bender.yml */
package:
  name: rv_mini_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_mini_core_pkg.sv
      - source/rv_register_file.sv
      - source/rv_if_stage.sv
      - source/rv_id_stage.sv
      - source/rv_ex_stage.sv
      - source/rv_mini_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_rv_mini_core.sv

/* testbench/rv_mini_core_input.txt */
# P <address> <instruction word>  assembly after the word is ignored
# S <test name> <store address> <store data>  expected stores in program order
P 00000080 12300093  addi x1, x0, 0x123
P 00000084 10102023  sw   x1, 0x100(x0)
P 00000088 12345137  lui  x2, 0x12345
P 0000008c 10202223  sw   x2, 0x104(x0)
P 00000090 00208233  add  x4, x1, x2
P 00000094 402082b3  sub  x5, x1, x2
P 00000098 00524333  xor  x6, x4, x5
P 0000009c 001363b3  or   x7, x6, x1
P 000000a0 0053f433  and  x8, x7, x5
P 000000a4 10802423  sw   x8, 0x108(x0)
P 000000a8 fff24493  xori x9, x4, -1
P 000000ac 0f04e493  ori  x9, x9, 0x0f0
P 000000b0 7ff4f513  andi x10, x9, 0x7ff
P 000000b4 10a02623  sw   x10, 0x10c(x0)
P 000000b8 05500013  addi x0, x0, 0x55
P 000000bc 10002823  sw   x0, 0x110(x0)
P 000000c0 20000593  addi x11, x0, 0x200
P 000000c4 fe55ae23  sw   x5, -4(x11)
P 000000c8 00000073  ecall, not supported
P 000000cc 10102a23  sw   x1, 0x114(x0)
S addi        00000100 00000123
S lui         00000104 12345000
S alu_chain   00000108 edcba123
S imm_logic   0000010c 000006fc
S x0_zero     00000110 00000000
S base_fwd    000001fc edcbb123
S after_unsup 00000114 00000123
